// ==== common/fifo_bank_pkg.sv ====
`default_nettype none

package fifo_bank_pkg;

    // ------------------------------------------------
    // Bank geometry
    // ------------------------------------------------
    // Number of FIFO lanes
    localparam int NUM_CHAN   = 4;
    // Memory words per lane
    localparam int LANE_DEPTH = 8;
    // Payload width
    localparam int DATA_WID   = 16;

    // ------------------------------------------------
    // Derived widths
    // ------------------------------------------------
    localparam int CHAN_WID = $clog2(NUM_CHAN);
    localparam int PTR_WID  = $clog2(LANE_DEPTH);
    // Memory words plus the FWFT prefetch word
    localparam int CNT_WID  = $clog2(LANE_DEPTH + 1 + 1);

    // Payload word
    typedef logic [DATA_WID-1:0] data_t;
    // Lane number
    typedef logic [CHAN_WID-1:0] chan_t;
    // Lane memory address
    typedef logic [PTR_WID-1:0]  ptr_t;
    // Lane occupancy
    typedef logic [CNT_WID-1:0]  cnt_t;

    // Drainer states
    typedef enum logic [1:0] {
        DRAIN_IDLE,
        DRAIN_POP,
        DRAIN_HOLD
    } drain_state_t;

endpackage : fifo_bank_pkg

`default_nettype wire

// ==== common/fifo_lane_intf.sv ====
`default_nettype none
`timescale 1ns/1ps

interface fifo_lane_intf;

    import fifo_bank_pkg::*;

    // ------------------------------------------------
    // Write side
    // ------------------------------------------------
    logic  wr;
    data_t wr_data;
    // Lane memory full, write would be dropped
    logic  full;
    // Pulses with a dropped write
    logic  oflow;

    // ------------------------------------------------
    // Read side
    // ------------------------------------------------
    // Pops the word shown on rd_data
    logic  rd;
    data_t rd_data;
    // High until the prefetch holds a word
    logic  empty;
    // Memory plus prefetch occupancy
    cnt_t  count;
    // Pulses with a read of an empty lane
    logic  uflow;

    // Demultiplexer view
    modport src (output wr, output wr_data, input full, input oflow);

    // FIFO lane view
    modport lane (
        input  wr, input  wr_data, output full, output oflow,
        input  rd, output rd_data, output empty, output count, output uflow
    );

    // Drainer view
    modport snk (output rd, input rd_data, input empty, input count, input uflow);

endinterface : fifo_lane_intf

`default_nettype wire

// ==== fifo_core/fifo_ctrl_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module fifo_ctrl_fsm (
    input  logic                rd_clk,
    input  logic                local_rd_srst,
    // Write request side
    input  logic                wr,
    output logic                wr_safe,
    output fifo_bank_pkg::ptr_t wr_ptr,
    output logic                full,
    output logic                oflow,
    // Read request side
    input  logic                rd,
    output logic                rd_safe,
    output fifo_bank_pkg::ptr_t rd_ptr,
    output logic                mem_empty,
    output fifo_bank_pkg::cnt_t mem_count
);

    import fifo_bank_pkg::*;

    // Occupancy after this edge
    cnt_t count_nxt;

    // ------------------------------------------------
    // Request protection
    // ------------------------------------------------
    // No write into a full memory
    assign wr_safe = wr && !full;
    // No read from an empty memory
    assign rd_safe = rd && !mem_empty;

    // Dropped write flagged in its own cycle
    assign oflow = wr && full;

    // ------------------------------------------------
    // Pointers
    // ------------------------------------------------
    // Both wrap at LANE_DEPTH
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            wr_ptr <= '0;
        end else if (wr_safe) begin
            wr_ptr <= (wr_ptr == ptr_t'(LANE_DEPTH - 1)) ? '0 : ptr_t'(wr_ptr + 1'b1);
        end
    end

    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            rd_ptr <= '0;
        end else if (rd_safe) begin
            rd_ptr <= (rd_ptr == ptr_t'(LANE_DEPTH - 1)) ? '0 : ptr_t'(rd_ptr + 1'b1);
        end
    end

    // ------------------------------------------------
    // Occupancy and flags
    // ------------------------------------------------
    // Up on write, down on read, same on both
    always_comb begin
        case ({wr_safe, rd_safe})
            2'b10:   count_nxt = cnt_t'(mem_count + 1'b1);
            2'b01:   count_nxt = cnt_t'(mem_count - 1'b1);
            default: count_nxt = mem_count;
        endcase
    end

    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            mem_count <= '0;
            full      <= 1'b0;
            mem_empty <= 1'b1;
        end else begin
            mem_count <= count_nxt;
            full      <= (count_nxt == cnt_t'(LANE_DEPTH));
            // Empty drops one cycle late after a write into an empty memory
            // goes high at once on the last read
            mem_empty <= (count_nxt == '0) || (mem_count == '0);
        end
    end

endmodule : fifo_ctrl_fsm

`default_nettype wire

// ==== fifo_core/fifo_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module fifo_core (
    input  logic       rd_clk,
    input  logic       local_rd_srst,
    // Write and read sides of one lane
    fifo_lane_intf.lane lane_if
);

    import fifo_bank_pkg::*;

    // ------------------------------------------------
    // Signals
    // ------------------------------------------------
    // Protected strobes and addresses from the controller
    logic  wr_safe;
    ptr_t  wr_ptr;
    logic  rd_safe;
    ptr_t  rd_ptr;

    // Internal read request for prefetch or pop
    logic  mem_rd;
    cnt_t  mem_count;

    // Storage
    data_t mem [LANE_DEPTH];
    data_t rd_data_q;

    // FWFT buffer has no valid word
    logic  buf_empty;

    // ------------------------------------------------
    // Pointer and count control
    // ------------------------------------------------
    fifo_ctrl_fsm i_fifo_ctrl_fsm (
        .rd_clk        ( rd_clk ),
        .local_rd_srst ( local_rd_srst ),
        .wr            ( lane_if.wr ),
        .wr_safe       ( wr_safe ),
        .wr_ptr        ( wr_ptr ),
        .full          ( lane_if.full ),
        .oflow         ( lane_if.oflow ),
        .rd            ( mem_rd ),
        .rd_safe       ( rd_safe ),
        .rd_ptr        ( rd_ptr ),
        .mem_empty     ( ),
        .mem_count     ( mem_count )
    );

    // ------------------------------------------------
    // Lane memory
    // ------------------------------------------------
    // Write only when not full
    always_ff @(posedge rd_clk) begin
        if (wr_safe) begin
            mem[wr_ptr] <= lane_if.wr_data;
        end
    end

    // One-cycle registered read
    // doubles as the prefetch register
    always_ff @(posedge rd_clk) begin
        if (rd_safe) begin
            rd_data_q <= mem[rd_ptr];
        end
    end

    // ------------------------------------------------
    // FWFT prefetch
    // ------------------------------------------------
    // Fetch while the buffer is empty, or refill on pop
    assign mem_rd = buf_empty || lane_if.rd;

    // Buffer fills on any fetched word
    // and drains on a pop with nothing behind it
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            buf_empty <= 1'b1;
        end else if (rd_safe) begin
            buf_empty <= 1'b0;
        end else if (lane_if.rd) begin
            buf_empty <= 1'b1;
        end
    end

    assign lane_if.empty   = buf_empty;
    assign lane_if.rd_data = rd_data_q;

    // Count includes the word in the buffer
    assign lane_if.count = buf_empty ? mem_count : cnt_t'(mem_count + 1'b1);

    // Pop with nothing shown is ignored by the buffer
    assign lane_if.uflow = lane_if.rd && buf_empty;

endmodule : fifo_core

`default_nettype wire

// ==== src/chan_demux.sv ====
`default_nettype none
`timescale 1ns/1ps

module chan_demux (
    input  logic                  rd_clk,
    input  logic                  local_rd_srst,
    // Tagged write stream
    input  logic                  in_wr,
    input  fifo_bank_pkg::chan_t  in_chan,
    input  fifo_bank_pkg::data_t  in_data,
    output logic                  in_oflow,
    // One write side per lane
    fifo_lane_intf.src            lane_if [fifo_bank_pkg::NUM_CHAN]
);

    import fifo_bank_pkg::*;

    // ------------------------------------------------
    // Input register
    // ------------------------------------------------
    logic                wr_q;
    chan_t               chan_q;
    data_t               data_q;
    // Overflow pulses from all lanes
    logic [NUM_CHAN-1:0] oflow_vec;

    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= in_wr;
        end
    end

    // Channel and payload held with the strobe
    always_ff @(posedge rd_clk) begin
        if (in_wr) begin
            chan_q <= in_chan;
            data_q <= in_data;
        end
    end

    // ------------------------------------------------
    // Lane decode
    // ------------------------------------------------
    // Lane tests full itself, write forwarded as is
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_lane_wr
        assign lane_if[i].wr      = wr_q && (chan_q == chan_t'(i));
        assign lane_if[i].wr_data = data_q;
        assign oflow_vec[i]       = lane_if[i].oflow;
    end

    // Only the addressed lane can drop, so OR is enough
    assign in_oflow = |oflow_vec;

endmodule : chan_demux

`default_nettype wire

// ==== src/rr_drain.sv ====
`default_nettype none
`timescale 1ns/1ps

module rr_drain (
    input  logic                 rd_clk,
    input  logic                 local_rd_srst,
    input  logic                 out_en,
    // One read side per lane
    fifo_lane_intf.snk           lane_if [fifo_bank_pkg::NUM_CHAN],
    // Tagged output stream
    output logic                 out_valid,
    output fifo_bank_pkg::chan_t out_chan,
    output fifo_bank_pkg::data_t out_data,
    output fifo_bank_pkg::cnt_t [fifo_bank_pkg::NUM_CHAN-1:0] lane_count
);

    import fifo_bank_pkg::*;

    // ------------------------------------------------
    // Signals
    // ------------------------------------------------
    drain_state_t        state;
    drain_state_t        state_nxt;
    // Lane popped in DRAIN_POP, and last lane served
    chan_t               sel_q;
    chan_t               last_q;
    // Search start and result
    chan_t               base;
    chan_t               pick;
    logic                found;
    logic                pop_fire;
    logic [NUM_CHAN-1:0] empty_vec;
    logic [NUM_CHAN-1:0] elig;
    logic [NUM_CHAN-1:0] rd_vec;
    data_t               data_vec [NUM_CHAN];

    // Flatten the lane array
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_lane_io
        assign empty_vec[i]  = lane_if[i].empty;
        assign data_vec[i]   = lane_if[i].rd_data;
        assign lane_count[i] = lane_if[i].count;
        assign lane_if[i].rd = rd_vec[i];
    end

    // ------------------------------------------------
    // Pop strobe
    // ------------------------------------------------
    // Lane chosen a cycle earlier, dropped when out_en falls
    assign pop_fire = (state == DRAIN_POP) && out_en;

    always_comb begin
        rd_vec        = '0;
        rd_vec[sel_q] = pop_fire;
    end

    // ------------------------------------------------
    // Round-robin search
    // ------------------------------------------------
    always_comb begin
        elig = ~empty_vec;
        base = last_q;
        // Lane being popped has a stale empty
        if (state == DRAIN_POP) begin
            elig[sel_q] = 1'b0;
            base        = sel_q;
        end
        // Just popped lane skipped once more
        if (state == DRAIN_HOLD) begin
            elig[last_q] = 1'b0;
        end
    end

    // First eligible lane after base, base itself last
    always_comb begin
        found = 1'b0;
        pick  = base;
        for (int k = 1; k <= NUM_CHAN; k++) begin
            if (!found && elig[(int'(base) + k) % NUM_CHAN]) begin
                found = 1'b1;
                pick  = chan_t'((int'(base) + k) % NUM_CHAN);
            end
        end
    end

    always_comb begin
        state_nxt = DRAIN_IDLE;
        if (out_en && found) begin
            state_nxt = DRAIN_POP;
        end else if (pop_fire) begin
            state_nxt = DRAIN_HOLD;
        end
    end

    // Start search at lane 0 after reset
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            state  <= DRAIN_IDLE;
            sel_q  <= '0;
            last_q <= chan_t'(NUM_CHAN - 1);
        end else begin
            state <= state_nxt;
            if (out_en && found) begin
                sel_q <= pick;
            end
            if (pop_fire) begin
                last_q <= sel_q;
            end
        end
    end

    // ------------------------------------------------
    // Output stage
    // ------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop_fire;
        end
    end

    // Word shown by the lane at the pop edge
    always_ff @(posedge rd_clk) begin
        if (pop_fire) begin
            out_data <= data_vec[sel_q];
            out_chan <= sel_q;
        end
    end

endmodule : rr_drain

`default_nettype wire

// ==== src/fifo_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

module fifo_bank (
    input  logic                 rd_clk,
    input  logic                 local_rd_srst,
    // Write stream, one channel tag per word
    input  logic                 in_wr,
    input  fifo_bank_pkg::chan_t in_chan,
    input  fifo_bank_pkg::data_t in_data,
    output logic                 in_oflow,
    // Drained output stream
    input  logic                 out_en,
    output logic                 out_valid,
    output fifo_bank_pkg::chan_t out_chan,
    output fifo_bank_pkg::data_t out_data,
    // Per-lane occupancy
    output fifo_bank_pkg::cnt_t [fifo_bank_pkg::NUM_CHAN-1:0] lane_count
);

    import fifo_bank_pkg::*;

    // One bundle per lane
    fifo_lane_intf lane_if [NUM_CHAN] ();

    // ------------------------------------------------
    // Input demultiplexer
    // ------------------------------------------------
    chan_demux i_chan_demux (
        .rd_clk        ( rd_clk ),
        .local_rd_srst ( local_rd_srst ),
        .in_wr         ( in_wr ),
        .in_chan       ( in_chan ),
        .in_data       ( in_data ),
        .in_oflow      ( in_oflow ),
        .lane_if       ( lane_if )
    );

    // ------------------------------------------------
    // FWFT lanes
    // ------------------------------------------------
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_lane
        fifo_core i_fifo_core (
            .rd_clk        ( rd_clk ),
            .local_rd_srst ( local_rd_srst ),
            .lane_if       ( lane_if[i] )
        );
    end

    // ------------------------------------------------
    // Round-robin drainer
    // ------------------------------------------------
    rr_drain i_rr_drain (
        .rd_clk        ( rd_clk ),
        .local_rd_srst ( local_rd_srst ),
        .out_en        ( out_en ),
        .lane_if       ( lane_if ),
        .out_valid     ( out_valid ),
        .out_chan      ( out_chan ),
        .out_data      ( out_data ),
        .lane_count    ( lane_count )
    );

endmodule : fifo_bank

`default_nettype wire

// ==== bench/fifo_bank_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module fifo_bank_asserts (
    input  logic                 rd_clk,
    input  logic                 local_rd_srst,
    input  logic                 in_oflow,
    input  logic                 out_en,
    input  logic                 out_valid,
    input  fifo_bank_pkg::chan_t out_chan,
    input  fifo_bank_pkg::cnt_t [fifo_bank_pkg::NUM_CHAN-1:0] lane_count
);

    import fifo_bank_pkg::*;

    // Failed assertions so far
    int unsigned fail_count = 0;

    // Lane counts one edge back
    cnt_t [NUM_CHAN-1:0] count_q;
    // Bit d of owed[c] set while lane d must be served before lane c again
    logic [NUM_CHAN-1:0] owed [NUM_CHAN];

    // ------------------------------------------------
    // Round-robin bookkeeping
    // ------------------------------------------------
    // Three or more words means the prefetch buffer is full,
    // so such a lane was eligible when the pop was chosen
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            count_q <= '0;
            for (int c = 0; c < NUM_CHAN; c++) begin
                owed[c] <= '0;
            end
        end else begin
            count_q <= lane_count;
            if (out_valid) begin
                for (int d = 0; d < NUM_CHAN; d++) begin
                    owed[d][out_chan] <= 1'b0;
                    owed[out_chan][d] <= (d != int'(out_chan)) && (count_q[d] >= cnt_t'(3));
                end
            end
        end
    end

    // ------------------------------------------------
    // Properties
    // ------------------------------------------------
    // Quiet outputs and empty lanes as reset ends
    a_reset_quiet: assert property (@(posedge rd_clk)
        $fell(local_rd_srst) |-> !out_valid && !in_oflow && (lane_count == '0))
    else begin
        fail_count++;
        $error("Outputs not idle or lanes not empty after reset");
    end

    // No lane served twice while a loaded lane waits
    a_round_robin: assert property (@(posedge rd_clk) disable iff (local_rd_srst)
        out_valid |-> (owed[out_chan] == '0))
    else begin
        fail_count++;
        $error("Channel %0d served again before a waiting channel", out_chan);
    end

    // Output stops one cycle after out_en falls
    a_stop_on_disable: assert property (@(posedge rd_clk) disable iff (local_rd_srst)
        !out_en |=> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high although out_en was low");
    end

endmodule : fifo_bank_asserts

bind fifo_bank fifo_bank_asserts asserts_i (
    .rd_clk        ( rd_clk ),
    .local_rd_srst ( local_rd_srst ),
    .in_oflow      ( in_oflow ),
    .out_en        ( out_en ),
    .out_valid     ( out_valid ),
    .out_chan      ( out_chan ),
    .lane_count    ( lane_count )
);

`default_nettype wire

// ==== bench/fifo_bank_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module fifo_bank_tb;

    import fifo_bank_pkg::*;

    // Well above the roughly 800 cycles of the test sequence
    localparam int MAX_CYCLES = 4000;

    logic                rd_clk;
    logic                local_rd_srst;
    logic                in_wr;
    chan_t               in_chan;
    data_t               in_data;
    logic                in_oflow;
    logic                out_en;
    logic                out_valid;
    chan_t               out_chan;
    data_t               out_data;
    cnt_t [NUM_CHAN-1:0] lane_count;

    // Expected words per channel, oldest first
    data_t       ref_q [NUM_CHAN][$];
    // Drop expected for the write driven last cycle
    logic        oflow_exp;
    int unsigned cycle_cnt;
    int unsigned mismatch_cnt;
    int unsigned other_cnt;

    fifo_bank dut_i (
        .rd_clk        ( rd_clk ),
        .local_rd_srst ( local_rd_srst ),
        .in_wr         ( in_wr ),
        .in_chan       ( in_chan ),
        .in_data       ( in_data ),
        .in_oflow      ( in_oflow ),
        .out_en        ( out_en ),
        .out_valid     ( out_valid ),
        .out_chan      ( out_chan ),
        .out_data      ( out_data ),
        .lane_count    ( lane_count )
    );

    always #5 rd_clk = ~rd_clk;

    // ------------------------------------------------
    // Checking and driving helpers
    // ------------------------------------------------
    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_cnt, other_cnt, dut_i.asserts_i.fail_count);
    endtask

    // Check stable outputs on the falling edge and release the write
    task automatic tick();
        data_t exp_word;
        @(negedge rd_clk);
        if (in_oflow !== oflow_exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: in_oflow is %b, expected %b", $time, in_oflow, oflow_exp);
        end
        if (out_valid === 1'b1) begin
            if (ref_q[out_chan].size() == 0) begin
                other_cnt++;
                $display("Word %h came out on channel %0d at %0t with none queued there",
                         out_data, out_chan, $time);
            end else begin
                exp_word = ref_q[out_chan].pop_front();
                if (out_data !== exp_word) begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t: out_data on channel %0d is %h, expected %h",
                             $time, out_chan, out_data, exp_word);
                end
            end
        end else if (out_valid !== 1'b0) begin
            other_cnt++;
            $display("out_valid is unknown at %0t", $time);
        end
        in_wr     = 1'b0;
        oflow_exp = 1'b0;
    endtask

    // Lane holds LANE_DEPTH+1 words at most with the prefetch word
    task automatic send_word(input chan_t chan, input data_t data);
        tick();
        in_wr   = 1'b1;
        in_chan = chan;
        in_data = data;
        if (ref_q[chan].size() >= LANE_DEPTH + 1) begin
            oflow_exp = 1'b1;
        end else begin
            ref_q[chan].push_back(data);
        end
    endtask

    function automatic int queued_words();
        int sum;
        sum = 0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            sum += ref_q[c].size();
        end
        return sum;
    endfunction

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (queued_words() != 0 && n < limit) begin
            tick();
            n++;
        end
        if (queued_words() != 0) begin
            other_cnt++;
            $display("%0d words still queued after %0d cycles of draining", queued_words(), limit);
        end
    endtask

    // Random writes kept well below full while draining
    task automatic random_traffic(input int cycles);
        chan_t chan;
        for (int i = 0; i < cycles; i++) begin
            chan = chan_t'($urandom % NUM_CHAN);
            if (($urandom % 2) == 0 && ref_q[chan].size() < LANE_DEPTH - 2) begin
                send_word(chan, data_t'($urandom));
            end else begin
                tick();
            end
        end
    endtask

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        rd_clk        = 1'b0;
        local_rd_srst = 1'b1;
        in_wr         = 1'b0;
        in_chan       = '0;
        in_data       = '0;
        out_en        = 1'b0;
        oflow_exp     = 1'b0;
        cycle_cnt     = 0;
        mismatch_cnt  = 0;
        other_cnt     = 0;
        void'($urandom(83723));

        repeat (8) tick();
        local_rd_srst = 1'b0;
        out_en        = 1'b1;

        // Random traffic with the drainer running
        random_traffic(600);
        wait_drained(200);

        // Overfill channel 2 while stalled so the last word is dropped
        out_en = 1'b0;
        repeat (2) tick();
        for (int i = 0; i < LANE_DEPTH + 2; i++) begin
            send_word(chan_t'(2), data_t'({4'hA, 4'h2, 8'(i)}));
        end
        for (int n = 0; n < 8 && lane_count[2] !== cnt_t'(LANE_DEPTH + 1); n++) begin
            tick();
        end
        if (lane_count[2] !== cnt_t'(LANE_DEPTH + 1)) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: lane_count[2] is %0d, expected %0d",
                     $time, lane_count[2], LANE_DEPTH + 1);
        end

        // Load the other lanes and drain with out_en pulsed
        for (int i = 0; i < 6; i++) begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (ref_q[c].size() < LANE_DEPTH + 1) begin
                    send_word(chan_t'(c), data_t'({4'h5, 4'(c), 8'(i)}));
                end
            end
        end
        repeat (2) tick();
        for (int n = 0; n < 40; n++) begin
            tick();
            out_en = ((n % 9) < 6);
        end
        out_en = 1'b1;
        wait_drained(200);

        repeat (6) tick();
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (lane_count[c] !== '0) begin
                mismatch_cnt++;
                $display("Mismatch at %0t: lane_count[%0d] is %0d, expected 0",
                         $time, c, lane_count[c]);
            end
        end

        report_counts();
        if (mismatch_cnt + other_cnt + dut_i.asserts_i.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Run limit
    always @(posedge rd_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycle_cnt);
            report_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule : fifo_bank_tb

`default_nettype wire

// ==== fifo_bank.f ====
common/fifo_bank_pkg.sv
common/fifo_lane_intf.sv
fifo_core/fifo_ctrl_fsm.sv
fifo_core/fifo_core.sv
src/chan_demux.sv
src/rr_drain.sv
src/fifo_bank.sv
bench/fifo_bank_asserts.sv
bench/fifo_bank_tb.sv
